//--- include/pagerank_macros.svh
// PageRank compute unit widths and offsets

`ifndef PAGERANK_MACROS_SVH
`define PAGERANK_MACROS_SVH

// Memory format widths
`define PR_ADDR_W 32
`define PR_DATA_W 32
`define PR_DEG_W 16

// Queue and command FIFO depths, powers of two
`define PR_JOB_DEPTH 8
`define PR_CMD_DEPTH 8

//////////////////////////////////////////////////
// APB register map
//////////////////////////////////////////////////

`define PR_REG_CTRL      32'h0000_0000
`define PR_REG_EDGE_BASE 32'h0000_0004
`define PR_REG_RANK_BASE 32'h0000_0008

`endif

//--- logic/pagerank_pkg.sv
// PageRank compute unit types

`default_nettype none

`include "pagerank_macros.svh"

package pagerank_pkg;

	typedef logic [`PR_ADDR_W-1:0] addr_t;
	typedef logic [`PR_DATA_W-1:0] vertex_id_t;
	typedef logic [`PR_DEG_W-1:0]  degree_t;
	// Unsigned fixed point, sums wrap at 32 bits
	typedef logic [`PR_DATA_W-1:0] rank_t;

	// Which array a read belongs to
	typedef enum logic {
		TAG_EDGE,
		TAG_RANK
	} array_tag_t;

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		DRAIN
	} walker_state_t;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	// edge_start is an index into the edge list
	typedef struct packed {
		vertex_id_t vertex;
		vertex_id_t edge_start;
		degree_t    degree;
	} vertex_job_t;

	typedef struct packed {
		logic       valid;
		array_tag_t tag;
		addr_t      addr;
	} read_cmd_t;

	typedef struct packed {
		logic       valid;
		array_tag_t tag;
		rank_t      data;
	} read_resp_t;

	typedef struct packed {
		logic       valid;
		vertex_id_t vertex;
		rank_t      sum;
	} rank_write_t;

	typedef struct packed {
		logic  enable;
		addr_t edge_base;
		addr_t rank_base;
	} cu_config_t;

endpackage

`default_nettype wire

//--- logic/cu_config_apb.sv
// APB configuration registers

`timescale 1ns/100ps
`default_nettype none

`include "pagerank_macros.svh"

module cu_config_apb (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  pagerank_pkg::addr_t      paddr,
	input  pagerank_pkg::rank_t      pwdata,
	output pagerank_pkg::rank_t      prdata,
	output logic                     pready,
	output pagerank_pkg::cu_config_t cfg
);

	logic                enable;
	pagerank_pkg::addr_t edge_base;
	pagerank_pkg::addr_t rank_base;
	logic                wr_en;

	// No wait states
	assign pready = 1'b1;
	assign wr_en  = psel && penable && pwrite;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable    <= 1'b0;
			edge_base <= '0;
			rank_base <= '0;
		end else if (wr_en) begin
			case (paddr)
				`PR_REG_CTRL:      enable    <= pwdata[0];
				`PR_REG_EDGE_BASE: edge_base <= pwdata;
				`PR_REG_RANK_BASE: rank_base <= pwdata;
				default: ;
			endcase
		end
	end

	// Readback, unmapped offsets read zero
	always_comb begin
		case (paddr)
			`PR_REG_CTRL:      prdata = {{(`PR_DATA_W-1){1'b0}}, enable};
			`PR_REG_EDGE_BASE: prdata = edge_base;
			`PR_REG_RANK_BASE: prdata = rank_base;
			default:           prdata = '0;
		endcase
	end

	assign cfg.enable    = enable;
	assign cfg.edge_base = edge_base;
	assign cfg.rank_base = rank_base;

	// Access phase must follow a selected setup phase
	a_penable_needs_psel: assert property (
		@(posedge clock) disable iff (!rstn) penable |-> psel
	);

endmodule

`default_nettype wire

//--- logic/vertex_job_queue.sv
// Vertex job queue

`timescale 1ns/100ps
`default_nettype none

`include "pagerank_macros.svh"

module vertex_job_queue (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::vertex_job_t job_in,
	input  logic                      job_valid,
	output logic                      job_ready,
	output pagerank_pkg::vertex_job_t head,
	output logic                      head_valid,
	input  logic                      job_take
);

	localparam int PTR_W = $clog2(`PR_JOB_DEPTH);

	pagerank_pkg::vertex_job_t mem [`PR_JOB_DEPTH];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [PTR_W:0]            count;
	logic                      live;
	logic                      push;

	// Intake closed during reset and while full
	assign job_ready  = live && (count != (PTR_W+1)'(`PR_JOB_DEPTH));
	assign push       = job_valid && job_ready;
	assign head       = mem[rd_ptr];
	assign head_valid = (count != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			live   <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			live <= 1'b1;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (job_take)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(job_take);
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= job_in;
	end

	a_no_take_when_empty: assert property (
		@(posedge clock) disable iff (!rstn) job_take |-> head_valid
	);

endmodule

`default_nettype wire

//--- logic/edge_walker.sv
// Edge list walker

`timescale 1ns/100ps
`default_nettype none

module edge_walker (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::cu_config_t  cfg,
	input  pagerank_pkg::vertex_job_t head,
	input  logic                      head_valid,
	input  logic                      acc_busy,
	output logic                      job_take,
	output logic                      vertex_start,
	input  pagerank_pkg::read_resp_t  edge_resp,
	output pagerank_pkg::read_cmd_t   edge_cmd,
	input  logic                      edge_cmd_ready,
	output pagerank_pkg::read_cmd_t   rank_cmd,
	input  logic                      rank_cmd_ready,
	output pagerank_pkg::degree_t     edges_issued
);

	pagerank_pkg::walker_state_t state;
	pagerank_pkg::vertex_id_t    edge_start;
	pagerank_pkg::degree_t       degree;
	pagerank_pkg::degree_t       edge_sent;
	pagerank_pkg::degree_t       rank_sent;
	pagerank_pkg::vertex_id_t    edge_index;
	pagerank_pkg::addr_t         hold_addr;
	logic                        hold_valid;
	logic                        edge_wait;
	logic                        edge_fire;
	logic                        rank_fire;
	logic                        edge_back;

	// One vertex at a time, accumulator must be free
	assign job_take     = (state == pagerank_pkg::IDLE) && head_valid && cfg.enable && !acc_busy;
	assign vertex_start = job_take;

	assign edge_back  = edge_resp.valid && (edge_resp.tag == pagerank_pkg::TAG_EDGE);
	assign edge_index = edge_start + pagerank_pkg::vertex_id_t'(edge_sent);

	// Edge read waits for an empty holding register and no open edge read,
	// so a response always finds room
	always_comb begin
		edge_cmd.valid = (state == pagerank_pkg::WALK) && (edge_sent != degree) &&
		                 !edge_wait && !hold_valid;
		edge_cmd.tag   = pagerank_pkg::TAG_EDGE;
		edge_cmd.addr  = cfg.edge_base + {edge_index[29:0], 2'b00};
		rank_cmd.valid = hold_valid;
		rank_cmd.tag   = pagerank_pkg::TAG_RANK;
		rank_cmd.addr  = hold_addr;
	end

	assign edge_fire = edge_cmd.valid && edge_cmd_ready;
	assign rank_fire = rank_cmd.valid && rank_cmd_ready;

	//////////////////////////////////////////////////
	// Walker FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= pagerank_pkg::IDLE;
			edge_sent    <= '0;
			rank_sent    <= '0;
			edge_wait    <= 1'b0;
			hold_valid   <= 1'b0;
			edges_issued <= '0;
		end else begin
			case (state)
				pagerank_pkg::IDLE: begin
					if (job_take) begin
						edge_sent <= '0;
						rank_sent <= '0;
						// Degree 0 is finished by the accumulator alone
						if (head.degree != '0)
							state <= pagerank_pkg::WALK;
					end
				end
				pagerank_pkg::WALK: begin
					if (edge_fire && (pagerank_pkg::degree_t'(edge_sent + 16'd1) == degree))
						state <= pagerank_pkg::DRAIN;
				end
				pagerank_pkg::DRAIN: begin
					if (rank_sent == degree)
						state <= pagerank_pkg::IDLE;
				end
				default: state <= pagerank_pkg::IDLE;
			endcase
			if (edge_fire) begin
				edge_sent    <= edge_sent + 16'd1;
				edges_issued <= edges_issued + 16'd1;
				edge_wait    <= 1'b1;
			end else if (edge_back) begin
				edge_wait <= 1'b0;
			end
			if (edge_back)
				hold_valid <= 1'b1;
			else if (rank_fire)
				hold_valid <= 1'b0;
			if (rank_fire)
				rank_sent <= rank_sent + 16'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (job_take) begin
			edge_start <= head.edge_start;
			degree     <= head.degree;
		end
		// Neighbor ID to rank address
		if (edge_back)
			hold_addr <= cfg.rank_base + {edge_resp.data[29:0], 2'b00};
	end

	// A stray edge response would overwrite a pending rank read
	a_hold_not_overrun: assert property (
		@(posedge clock) disable iff (!rstn) edge_back |-> !hold_valid
	);

endmodule

`default_nettype wire

//--- logic/rank_accumulator.sv
// Rank accumulator

`timescale 1ns/100ps
`default_nettype none

module rank_accumulator (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      vertex_start,
	input  pagerank_pkg::vertex_job_t head,
	input  pagerank_pkg::read_resp_t  rank_resp,
	output logic                      acc_busy,
	output pagerank_pkg::rank_write_t rank_write,
	output pagerank_pkg::vertex_id_t  vertex_count
);

	logic                     busy;
	pagerank_pkg::vertex_id_t vertex;
	pagerank_pkg::degree_t    degree;
	pagerank_pkg::degree_t    count;
	pagerank_pkg::degree_t    next_count;
	pagerank_pkg::rank_t      sum;
	pagerank_pkg::rank_t      next_sum;
	logic                     rank_back;
	logic                     wr_valid;
	pagerank_pkg::vertex_id_t wr_vertex;
	pagerank_pkg::rank_t      wr_sum;
	logic                     last;

	assign rank_back  = rank_resp.valid && (rank_resp.tag == pagerank_pkg::TAG_RANK);
	assign next_count = count + 16'd1;
	assign next_sum   = sum + rank_resp.data;
	assign last       = rank_back && busy && (next_count == degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy         <= 1'b0;
			count        <= '0;
			wr_valid     <= 1'b0;
			vertex_count <= '0;
		end else begin
			wr_valid <= 1'b0;
			if (vertex_start) begin
				count <= '0;
				busy  <= (head.degree != '0);
				// Empty edge list completes at once
				if (head.degree == '0) begin
					wr_valid     <= 1'b1;
					vertex_count <= vertex_count + 1'b1;
				end
			end else if (rank_back && busy) begin
				count <= next_count;
				if (last) begin
					busy         <= 1'b0;
					wr_valid     <= 1'b1;
					vertex_count <= vertex_count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_start) begin
			vertex    <= head.vertex;
			degree    <= head.degree;
			sum       <= '0;
			wr_vertex <= head.vertex;
			wr_sum    <= '0;
		end else if (rank_back && busy) begin
			sum <= next_sum;
			if (last) begin
				wr_vertex <= vertex;
				wr_sum    <= next_sum;
			end
		end
	end

	assign acc_busy          = busy;
	assign rank_write.valid  = wr_valid;
	assign rank_write.vertex = wr_vertex;
	assign rank_write.sum    = wr_sum;

	a_rank_only_when_busy: assert property (
		@(posedge clock) disable iff (!rstn) rank_back |-> acc_busy
	);

endmodule

`default_nettype wire

//--- logic/read_command_port.sv
// Read command merge and bus port

`timescale 1ns/100ps
`default_nettype none

`include "pagerank_macros.svh"

module read_command_port (
	input  logic                    clock,
	input  logic                    rstn,
	input  pagerank_pkg::read_cmd_t edge_cmd,
	input  pagerank_pkg::read_cmd_t rank_cmd,
	output logic                    edge_cmd_ready,
	output logic                    rank_cmd_ready,
	input  logic                    read_bus_grant,
	output logic                    read_bus_request,
	output pagerank_pkg::read_cmd_t read_cmd
);

	localparam int PTR_W = $clog2(`PR_CMD_DEPTH);

	pagerank_pkg::read_cmd_t mem [`PR_CMD_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [PTR_W:0]          count;
	logic                    room;
	logic                    rank_turn;
	logic                    pick_rank;
	logic                    push;
	logic                    pop;
	pagerank_pkg::read_cmd_t push_cmd;

	//////////////////////////////////////////////////
	// Round-robin merge
	//////////////////////////////////////////////////

	// Stop accepting once almost full
	assign room      = (count < (PTR_W+1)'(`PR_CMD_DEPTH - 1));
	assign pick_rank = rank_cmd.valid && (rank_turn || !edge_cmd.valid);

	assign edge_cmd_ready = room && !pick_rank;
	assign rank_cmd_ready = room && pick_rank;

	assign push     = room && (edge_cmd.valid || rank_cmd.valid);
	assign push_cmd = pick_rank ? rank_cmd : edge_cmd;

	//////////////////////////////////////////////////
	// Command FIFO and bus side
	//////////////////////////////////////////////////

	assign read_bus_request = (count != '0);
	assign pop              = read_bus_grant && read_bus_request;

	always_comb begin
		read_cmd       = mem[rd_ptr];
		read_cmd.valid = pop;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			rank_turn <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr    <= wr_ptr + 1'b1;
				// Other source gets priority next
				rank_turn <= !pick_rank;
			end
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= push_cmd;
	end

	a_grant_needs_request: assert property (
		@(posedge clock) disable iff (!rstn) read_bus_grant |-> read_bus_request
	);

endmodule

`default_nettype wire

//--- logic/cu_vertex_pagerank.sv
// PageRank vertex compute unit

`timescale 1ns/100ps
`default_nettype none

module cu_vertex_pagerank (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  pagerank_pkg::addr_t       paddr,
	input  pagerank_pkg::rank_t       pwdata,
	output pagerank_pkg::rank_t       prdata,
	output logic                      pready,
	input  pagerank_pkg::vertex_job_t job_in,
	input  logic                      job_valid,
	output logic                      job_ready,
	output pagerank_pkg::read_cmd_t   read_cmd,
	output logic                      read_bus_request,
	input  logic                      read_bus_grant,
	input  pagerank_pkg::read_resp_t  read_resp,
	output pagerank_pkg::rank_write_t rank_write,
	output pagerank_pkg::vertex_id_t  vertex_count,
	output pagerank_pkg::degree_t     edges_issued
);

	pagerank_pkg::cu_config_t  cfg;
	pagerank_pkg::vertex_job_t head;
	logic                      head_valid;
	logic                      job_take;
	logic                      vertex_start;
	logic                      acc_busy;
	pagerank_pkg::read_cmd_t   edge_cmd;
	pagerank_pkg::read_cmd_t   rank_cmd;
	logic                      edge_cmd_ready;
	logic                      rank_cmd_ready;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	cu_config_apb u_config (
		.clock  (clock),
		.rstn   (rstn),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.cfg    (cfg)
	);

	vertex_job_queue u_job_queue (
		.clock     (clock),
		.rstn      (rstn),
		.job_in    (job_in),
		.job_valid (job_valid),
		.job_ready (job_ready),
		.head      (head),
		.head_valid(head_valid),
		.job_take  (job_take)
	);

	//////////////////////////////////////////////////
	// Processing, both consumers see every response
	//////////////////////////////////////////////////

	edge_walker u_walker (
		.clock         (clock),
		.rstn          (rstn),
		.cfg           (cfg),
		.head          (head),
		.head_valid    (head_valid),
		.acc_busy      (acc_busy),
		.job_take      (job_take),
		.vertex_start  (vertex_start),
		.edge_resp     (read_resp),
		.edge_cmd      (edge_cmd),
		.edge_cmd_ready(edge_cmd_ready),
		.rank_cmd      (rank_cmd),
		.rank_cmd_ready(rank_cmd_ready),
		.edges_issued  (edges_issued)
	);

	rank_accumulator u_accumulator (
		.clock       (clock),
		.rstn        (rstn),
		.vertex_start(vertex_start),
		.head        (head),
		.rank_resp   (read_resp),
		.acc_busy    (acc_busy),
		.rank_write  (rank_write),
		.vertex_count(vertex_count)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	read_command_port u_cmd_port (
		.clock           (clock),
		.rstn            (rstn),
		.edge_cmd        (edge_cmd),
		.rank_cmd        (rank_cmd),
		.edge_cmd_ready  (edge_cmd_ready),
		.rank_cmd_ready  (rank_cmd_ready),
		.read_bus_grant  (read_bus_grant),
		.read_bus_request(read_bus_request),
		.read_cmd        (read_cmd)
	);

endmodule

`default_nettype wire

//--- tests/pagerank_checker.sv
// PageRank result and register checker

`timescale 1ns/100ps
`default_nettype none

`include "pagerank_macros.svh"

module pagerank_checker (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  pagerank_pkg::addr_t       paddr,
	input  pagerank_pkg::rank_t       pwdata,
	input  pagerank_pkg::rank_t       prdata,
	input  logic                      pready,
	input  pagerank_pkg::rank_write_t rank_write,
	input  logic                      read_bus_request,
	input  logic                      read_bus_grant,
	input  pagerank_pkg::vertex_id_t  vertex_count,
	input  pagerank_pkg::degree_t     edges_issued,
	input  logic [8*16-1:0]           exp_name,
	input  pagerank_pkg::vertex_id_t  exp_vertex,
	input  pagerank_pkg::rank_t       exp_sum,
	input  pagerank_pkg::vertex_id_t  exp_jobs,
	input  pagerank_pkg::degree_t     exp_edges,
	input  logic                      final_check,
	output int                        result_index,
	output int                        error_count,
	output int                        check_count
);

	logic                shadow_enable;
	pagerank_pkg::addr_t shadow_edge_base;
	pagerank_pkg::addr_t shadow_rank_base;
	logic                last_request;
	logic                last_grant;

	task automatic compare_value(input logic [8*16-1:0] name, input logic [8*8-1:0] field,
		input logic [31:0] expected, input logic [31:0] actual);
		check_count = check_count + 1;
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("Error %0s %0s: expected 0x%08h, actual 0x%08h", name, field, expected, actual);
		end
	endtask

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			result_index     <= 0;
			error_count      = 0;
			check_count      = 0;
			shadow_enable    <= 1'b0;
			shadow_edge_base <= '0;
			shadow_rank_base <= '0;
			last_request     <= 1'b0;
			last_grant       <= 1'b0;
		end else begin
			//////////////////////////////////////////////////
			// APB shadow registers and readback
			//////////////////////////////////////////////////
			// Every access phase completes without wait states
			if (psel && penable)
				compare_value("apb_access", "pready", 32'd1, {31'b0, pready});
			if (psel && penable && pwrite) begin
				case (paddr)
					`PR_REG_CTRL:      shadow_enable    <= pwdata[0];
					`PR_REG_EDGE_BASE: shadow_edge_base <= pwdata;
					`PR_REG_RANK_BASE: shadow_rank_base <= pwdata;
					default: ;
				endcase
			end
			if (psel && penable && !pwrite) begin
				case (paddr)
					`PR_REG_CTRL:
						compare_value("apb_readback", "ctrl", {31'b0, shadow_enable}, prdata);
					`PR_REG_EDGE_BASE:
						compare_value("apb_readback", "edge", shadow_edge_base, prdata);
					`PR_REG_RANK_BASE:
						compare_value("apb_readback", "rank", shadow_rank_base, prdata);
					default: ;
				endcase
			end

			//////////////////////////////////////////////////
			// Results in job order
			//////////////////////////////////////////////////
			if (rank_write.valid) begin
				if (!shadow_enable) begin
					error_count = error_count + 1;
					$display("A result for vertex %0d came out while the unit was disabled",
						rank_write.vertex);
				end
				if (result_index >= int'(exp_jobs)) begin
					error_count = error_count + 1;
					$display("An extra result for vertex %0d came out after the last job",
						rank_write.vertex);
				end else begin
					compare_value(exp_name, "vertex", exp_vertex, rank_write.vertex);
					compare_value(exp_name, "sum", exp_sum, rank_write.sum);
				end
				result_index <= result_index + 1;
			end

			// Waiting commands keep the request up until granted
			if (last_request && !last_grant && !read_bus_request) begin
				error_count = error_count + 1;
				$display("The bus request dropped while a command was still waiting");
			end
			last_request <= read_bus_request;
			last_grant   <= read_bus_grant;

			if (final_check) begin
				compare_value("counters", "vertices", exp_jobs, vertex_count);
				compare_value("counters", "edges", {16'b0, exp_edges}, {16'b0, edges_issued});
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_cu_vertex_pagerank.sv
// PageRank compute unit testbench

`timescale 1ns/100ps
`default_nettype none

`include "pagerank_macros.svh"

module tb_cu_vertex_pagerank;

	localparam int          JOB_COUNT = 8;
	localparam int          ENABLE_AT = 3;
	localparam int          STALL_AT  = 5;
	localparam int          STALL_LEN = 200;
	localparam logic [31:0] EDGE_BASE = 32'h0001_0000;
	localparam logic [31:0] RANK_BASE = 32'h0002_0000;

	logic                      clock = 1'b0;
	logic                      rstn;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	pagerank_pkg::addr_t       paddr;
	pagerank_pkg::rank_t       pwdata;
	pagerank_pkg::rank_t       prdata;
	logic                      pready;
	pagerank_pkg::vertex_job_t job_in;
	logic                      job_valid;
	logic                      job_ready;
	pagerank_pkg::read_cmd_t   read_cmd;
	logic                      read_bus_request;
	logic                      read_bus_grant = 1'b0;
	pagerank_pkg::read_resp_t  read_resp = '0;
	pagerank_pkg::rank_write_t rank_write;
	pagerank_pkg::vertex_id_t  vertex_count;
	pagerank_pkg::degree_t     edges_issued;

	// Job table with expected sums from the memory format
	logic [8*16-1:0]          tbl_name   [JOB_COUNT];
	pagerank_pkg::vertex_id_t tbl_vertex [JOB_COUNT];
	pagerank_pkg::vertex_id_t tbl_start  [JOB_COUNT];
	pagerank_pkg::degree_t    tbl_degree [JOB_COUNT];
	pagerank_pkg::rank_t      tbl_sum    [JOB_COUNT];

	logic [8*16-1:0]          exp_name;
	pagerank_pkg::vertex_id_t exp_vertex;
	pagerank_pkg::rank_t      exp_sum;
	pagerank_pkg::vertex_id_t exp_jobs;
	pagerank_pkg::degree_t    exp_edges;
	logic                     final_check;
	int                       result_index;
	int                       error_count;
	int                       check_count;

	logic [31:0]              rand_state;
	logic                     grant_hold;
	int                       cycle = 0;
	int                       timeout_limit;
	pagerank_pkg::array_tag_t pend_tag  [$];
	pagerank_pkg::rank_t      pend_data [$];
	int                       pend_due  [$];

	always #5 clock = ~clock;

	cu_vertex_pagerank dut (
		.clock           (clock),
		.rstn            (rstn),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.job_in          (job_in),
		.job_valid       (job_valid),
		.job_ready       (job_ready),
		.read_cmd        (read_cmd),
		.read_bus_request(read_bus_request),
		.read_bus_grant  (read_bus_grant),
		.read_resp       (read_resp),
		.rank_write      (rank_write),
		.vertex_count    (vertex_count),
		.edges_issued    (edges_issued)
	);

	pagerank_checker u_checker (
		.clock           (clock),
		.rstn            (rstn),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.rank_write      (rank_write),
		.read_bus_request(read_bus_request),
		.read_bus_grant  (read_bus_grant),
		.vertex_count    (vertex_count),
		.edges_issued    (edges_issued),
		.exp_name        (exp_name),
		.exp_vertex      (exp_vertex),
		.exp_sum         (exp_sum),
		.exp_jobs        (exp_jobs),
		.exp_edges       (exp_edges),
		.final_check     (final_check),
		.result_index    (result_index),
		.error_count     (error_count),
		.check_count     (check_count)
	);

	// Table row for the next expected result
	always_comb begin
		exp_name   = '0;
		exp_vertex = '0;
		exp_sum    = '0;
		if (result_index < JOB_COUNT) begin
			exp_name   = tbl_name[result_index];
			exp_vertex = tbl_vertex[result_index];
			exp_sum    = tbl_sum[result_index];
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Neighbor of entry i is i mod 64 and its rank is 5n + 1
	function automatic pagerank_pkg::rank_t expected_sum(input pagerank_pkg::vertex_id_t start,
		input pagerank_pkg::degree_t degree);
		pagerank_pkg::rank_t      total;
		pagerank_pkg::vertex_id_t index;
		total = '0;
		for (int i = 0; i < int'(degree); i++) begin
			index = start + pagerank_pkg::vertex_id_t'(i);
			total = total + 32'd5 * (index % 32'd64) + 32'd1;
		end
		return total;
	endfunction

	function automatic void load_job(input int slot, input logic [8*16-1:0] name,
		input pagerank_pkg::vertex_id_t vertex, input pagerank_pkg::vertex_id_t start,
		input pagerank_pkg::degree_t degree);
		tbl_name[slot]   = name;
		tbl_vertex[slot] = vertex;
		tbl_start[slot]  = start;
		tbl_degree[slot] = degree;
		tbl_sum[slot]    = expected_sum(start, degree);
	endfunction

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	task automatic write_register(input pagerank_pkg::addr_t addr, input pagerank_pkg::rank_t data);
		@(posedge clock);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clock);
		penable <= 1'b1;
		@(posedge clock);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic read_register(input pagerank_pkg::addr_t addr);
		@(posedge clock);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clock);
		penable <= 1'b1;
		@(posedge clock);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic push_job(input int slot);
		@(posedge clock);
		job_in    <= {tbl_vertex[slot], tbl_start[slot], tbl_degree[slot]};
		job_valid <= 1'b1;
		@(posedge clock);
		while (!job_ready)
			@(posedge clock);
		job_valid <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Memory model and bus grant
	//////////////////////////////////////////////////

	always @(posedge clock or negedge rstn) begin : memory_model
		logic [31:0]              r;
		int                       slot;
		int                       delay;
		pagerank_pkg::rank_t      data;
		pagerank_pkg::addr_t      offset;
		pagerank_pkg::read_resp_t resp;
		if (!rstn) begin
			read_resp      <= '0;
			read_bus_grant <= 1'b0;
		end else begin
			if (read_cmd.valid) begin
				r     = next_random();
				delay = 1 + int'(r[18:16]);
				if (read_cmd.tag == pagerank_pkg::TAG_EDGE) begin
					offset = read_cmd.addr - EDGE_BASE;
					data   = (offset >> 2) % 32'd64;
				end else begin
					offset = read_cmd.addr - RANK_BASE;
					data   = 32'd5 * (offset >> 2) + 32'd1;
				end
				pend_tag.push_back(read_cmd.tag);
				pend_data.push_back(data);
				pend_due.push_back(cycle + delay);
			end
			// First due entry wins, so short delays overtake long ones
			slot = -1;
			for (int k = 0; k < pend_due.size(); k++) begin
				if (slot < 0 && pend_due[k] <= cycle)
					slot = k;
			end
			resp = '0;
			if (slot >= 0) begin
				resp.valid = 1'b1;
				resp.tag   = pend_tag[slot];
				resp.data  = pend_data[slot];
				pend_tag.delete(slot);
				pend_data.delete(slot);
				pend_due.delete(slot);
			end
			read_resp <= resp;
			// Grant only every other cycle so the request is still up
			r = next_random();
			read_bus_grant <= !grant_hold && read_bus_request && !read_bus_grant &&
			                  (r[21:20] != 2'b00);
		end
	end

	always @(posedge clock) begin
		if (rstn) begin
			cycle <= cycle + 1;
			if (cycle >= timeout_limit) begin
				$display("Timeout: %0d of %0d results after %0d cycles",
					result_index, JOB_COUNT, cycle);
				$display("Closing: %0d checks, %0d errors", check_count, error_count + 1);
				$display("test failed");
				$finish;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin : main
		int total_degree;
		rstn        = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		job_in      = '0;
		job_valid   = 1'b0;
		grant_hold  = 1'b0;
		final_check = 1'b0;
		rand_state  = 32'h925d5918;

		load_job(0, "disabled_a",   32'd10, 32'd0,   16'd3);
		load_job(1, "disabled_b",   32'd11, 32'd3,   16'd2);
		load_job(2, "degree_one",   32'd12, 32'd7,   16'd1);
		load_job(3, "degree_zero",  32'd13, 32'd9,   16'd0);
		load_job(4, "degree_twenty", 32'd14, 32'd50, 16'd20);
		load_job(5, "grant_stall",  32'd15, 32'd100, 16'd12);
		load_job(6, "after_stall",  32'd16, 32'd5,   16'd6);
		load_job(7, "far_start",    32'd17, 32'd200, 16'd9);

		total_degree = 0;
		for (int i = 0; i < JOB_COUNT; i++)
			total_degree = total_degree + int'(tbl_degree[i]);
		exp_jobs      = JOB_COUNT;
		exp_edges     = pagerank_pkg::degree_t'(total_degree);
		timeout_limit = total_degree * 40 + 500;

		wait_cycles(3);
		rstn <= 1'b1;

		write_register(`PR_REG_EDGE_BASE, EDGE_BASE);
		write_register(`PR_REG_RANK_BASE, RANK_BASE);
		read_register(`PR_REG_CTRL);
		read_register(`PR_REG_EDGE_BASE);
		read_register(`PR_REG_RANK_BASE);

		for (int i = 0; i < JOB_COUNT; i++) begin
			if (i == ENABLE_AT) begin
				// Queued jobs sit still until enable
				wait_cycles(40);
				write_register(`PR_REG_CTRL, 32'd1);
				read_register(`PR_REG_CTRL);
			end
			if (i == STALL_AT) begin
				while (result_index < STALL_AT)
					@(posedge clock);
				grant_hold <= 1'b1;
				push_job(i);
				wait_cycles(STALL_LEN);
				grant_hold <= 1'b0;
			end else begin
				push_job(i);
			end
		end

		while (result_index < JOB_COUNT)
			@(posedge clock);
		@(posedge clock);
		final_check <= 1'b1;
		@(posedge clock);
		final_check <= 1'b0;
		wait_cycles(2);

		$display("Closing: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- cu_vertex_pagerank.f
+incdir+include
logic/pagerank_pkg.sv
logic/cu_config_apb.sv
logic/vertex_job_queue.sv
logic/edge_walker.sv
logic/rank_accumulator.sv
logic/read_command_port.sv
logic/cu_vertex_pagerank.sv
tests/pagerank_checker.sv
tests/tb_cu_vertex_pagerank.sv

//--- Makefile
# Verilator build and run for the PageRank compute unit

VERILATOR ?= verilator
TOP       ?= tb_cu_vertex_pagerank
FILELIST  ?= cu_vertex_pagerank.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= test passed

SOURCES := $(wildcard logic/*.sv tests/*.sv include/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
